//--- rtl/aluStation_macros.svh
`ifndef ALU_STATION_MACROS_SVH
`define ALU_STATION_MACROS_SVH

`default_nettype none

////////////////////////////////////////////////////////////
// datapath widths
////////////////////////////////////////////////////////////

// one RV32 word, used for both data and instruction addresses
`define XLEN 32

// destination rename tag coming from the reservation station
`define TAG_W 4

////////////////////////////////////////////////////////////
// pipeline shape
////////////////////////////////////////////////////////////

// younger stages behind the result stage that a redirect kills
`define SQUASH_DEPTH 2

`default_nettype wire

`endif

//--- rtl/rvIsaPkg.sv
`default_nettype none

package rvIsaPkg;

    ////////////////////////////////////////////////////////////
    // RV32I major opcodes handled by the slice
    ////////////////////////////////////////////////////////////

    localparam logic [6:0] opcodeLui    = 7'b0110111;
    localparam logic [6:0] opcodeAuipc  = 7'b0010111;
    localparam logic [6:0] opcodeJal    = 7'b1101111;
    localparam logic [6:0] opcodeJalr   = 7'b1100111;
    localparam logic [6:0] opcodeBranch = 7'b1100011;
    localparam logic [6:0] opcodeOpImm  = 7'b0010011;
    localparam logic [6:0] opcodeOp     = 7'b0110011;

    // funct3 of the conditional branches
    localparam logic [2:0] f3Beq  = 3'b000;
    localparam logic [2:0] f3Bne  = 3'b001;
    localparam logic [2:0] f3Blt  = 3'b100;
    localparam logic [2:0] f3Bge  = 3'b101;
    localparam logic [2:0] f3Bltu = 3'b110;
    localparam logic [2:0] f3Bgeu = 3'b111;

    // funct3 of the ALU group, shared by OP and OP-IMM
    localparam logic [2:0] f3AddSub = 3'b000;
    localparam logic [2:0] f3Sll    = 3'b001;
    localparam logic [2:0] f3Slt    = 3'b010;
    localparam logic [2:0] f3Sltu   = 3'b011;
    localparam logic [2:0] f3Xor    = 3'b100;
    localparam logic [2:0] f3SrlSra = 3'b101;
    localparam logic [2:0] f3Or     = 3'b110;
    localparam logic [2:0] f3And    = 3'b111;

    localparam logic [2:0] f3Jalr = 3'b000; // the only legal funct3 for JALR

    // funct7 picks SUB/SRA over ADD/SRL
    localparam logic [6:0] f7Base = 7'b0000000;
    localparam logic [6:0] f7Alt  = 7'b0100000;

    ////////////////////////////////////////////////////////////
    // internal operations after decode
    ////////////////////////////////////////////////////////////

    typedef enum logic [4:0] {
        opLui, opAuipc, opJal, opJalr,
        opBeq, opBne, opBlt, opBge, opBltu, opBgeu,
        opAddi, opSlti, opSltiu, opXori, opOri, opAndi, opSlli, opSrli, opSrai,
        opAdd, opSub, opSll, opSlt, opSltu, opXor, opSrl, opSra, opOr, opAnd,
        opIllegal
    } opT;

endpackage

`default_nettype wire

//--- rtl/pipePkg.sv
`include "aluStation_macros.svh"

`default_nettype none

package pipePkg;

    ////////////////////////////////////////////////////////////
    // vectors that travel down the pipeline
    ////////////////////////////////////////////////////////////

    // register operand or broadcast result
    typedef logic [`XLEN-1:0] dataT;

    // PC of an instruction, also used for redirect targets
    typedef logic [`XLEN-1:0] addrT;

    // rename tag of the destination register
    typedef logic [`TAG_W-1:0] tagT;

endpackage

`default_nettype wire

//--- rtl/instrDecode.sv
`timescale 1ns/10ps
`default_nettype none

module instrDecode (
    input  wire                 clk,
    input  wire                 rst,
    input  wire                 rdy,
    input  wire                 flush,
    input  wire                 issueEn,
    input  wire pipePkg::addrT  issuePc,
    input  wire pipePkg::dataT  issueInstr,
    input  wire pipePkg::tagT   issueTag,
    input  wire pipePkg::dataT  rs1Data,
    input  wire pipePkg::dataT  rs2Data,
    output logic                decValid,
    output rvIsaPkg::opT        decOp,
    output pipePkg::dataT       decImm,
    output pipePkg::addrT       decPc,
    output pipePkg::tagT        decTag,
    output pipePkg::dataT       decRs1,
    output pipePkg::dataT       decRs2
);

    logic [6:0]    opcode;
    logic [2:0]    funct3;
    logic [6:0]    funct7;
    pipePkg::dataT immI;
    pipePkg::dataT immU;
    pipePkg::dataT immB;
    pipePkg::dataT immJ;
    rvIsaPkg::opT  nextOp;
    pipePkg::dataT nextImm;
    logic          validQ;

    assign opcode = issueInstr[6:0];
    assign funct3 = issueInstr[14:12];
    assign funct7 = issueInstr[31:25];

    ////////////////////////////////////////////////////////////
    // immediates, all sign extended from bit 31
    ////////////////////////////////////////////////////////////

    assign immI = {{20{issueInstr[31]}}, issueInstr[31:20]};
    assign immU = {issueInstr[31:12], 12'b0}; // already in its final position
    assign immB = {{19{issueInstr[31]}}, issueInstr[31], issueInstr[7],
                   issueInstr[30:25], issueInstr[11:8], 1'b0};
    assign immJ = {{11{issueInstr[31]}}, issueInstr[31], issueInstr[19:12],
                   issueInstr[20], issueInstr[30:21], 1'b0};

    always_comb begin
        nextOp  = rvIsaPkg::opIllegal; // anything not matched below
        nextImm = immI;
        case (opcode)
            rvIsaPkg::opcodeLui: begin
                nextOp  = rvIsaPkg::opLui;
                nextImm = immU;
            end
            rvIsaPkg::opcodeAuipc: begin
                nextOp  = rvIsaPkg::opAuipc;
                nextImm = immU;
            end
            rvIsaPkg::opcodeJal: begin
                nextOp  = rvIsaPkg::opJal;
                nextImm = immJ;
            end
            rvIsaPkg::opcodeJalr: begin
                if (funct3 == rvIsaPkg::f3Jalr) nextOp = rvIsaPkg::opJalr;
            end
            rvIsaPkg::opcodeBranch: begin
                nextImm = immB;
                case (funct3)
                    rvIsaPkg::f3Beq:  nextOp = rvIsaPkg::opBeq;
                    rvIsaPkg::f3Bne:  nextOp = rvIsaPkg::opBne;
                    rvIsaPkg::f3Blt:  nextOp = rvIsaPkg::opBlt;
                    rvIsaPkg::f3Bge:  nextOp = rvIsaPkg::opBge;
                    rvIsaPkg::f3Bltu: nextOp = rvIsaPkg::opBltu;
                    rvIsaPkg::f3Bgeu: nextOp = rvIsaPkg::opBgeu;
                    default:          nextOp = rvIsaPkg::opIllegal;
                endcase
            end
            rvIsaPkg::opcodeOpImm: begin
                case (funct3)
                    rvIsaPkg::f3AddSub: nextOp = rvIsaPkg::opAddi;
                    rvIsaPkg::f3Slt:    nextOp = rvIsaPkg::opSlti;
                    rvIsaPkg::f3Sltu:   nextOp = rvIsaPkg::opSltiu;
                    rvIsaPkg::f3Xor:    nextOp = rvIsaPkg::opXori;
                    rvIsaPkg::f3Or:     nextOp = rvIsaPkg::opOri;
                    rvIsaPkg::f3And:    nextOp = rvIsaPkg::opAndi;
                    rvIsaPkg::f3Sll: begin
                        if (funct7 == rvIsaPkg::f7Base) nextOp = rvIsaPkg::opSlli;
                    end
                    default: begin // shift right, funct7 sits in the upper immediate
                        if (funct7 == rvIsaPkg::f7Base) nextOp = rvIsaPkg::opSrli;
                        else if (funct7 == rvIsaPkg::f7Alt) nextOp = rvIsaPkg::opSrai;
                    end
                endcase
            end
            rvIsaPkg::opcodeOp: begin
                if (funct7 == rvIsaPkg::f7Base) begin
                    case (funct3)
                        rvIsaPkg::f3AddSub: nextOp = rvIsaPkg::opAdd;
                        rvIsaPkg::f3Sll:    nextOp = rvIsaPkg::opSll;
                        rvIsaPkg::f3Slt:    nextOp = rvIsaPkg::opSlt;
                        rvIsaPkg::f3Sltu:   nextOp = rvIsaPkg::opSltu;
                        rvIsaPkg::f3Xor:    nextOp = rvIsaPkg::opXor;
                        rvIsaPkg::f3SrlSra: nextOp = rvIsaPkg::opSrl;
                        rvIsaPkg::f3Or:     nextOp = rvIsaPkg::opOr;
                        default:            nextOp = rvIsaPkg::opAnd;
                    endcase
                end else if (funct7 == rvIsaPkg::f7Alt) begin
                    if (funct3 == rvIsaPkg::f3AddSub) nextOp = rvIsaPkg::opSub;
                    else if (funct3 == rvIsaPkg::f3SrlSra) nextOp = rvIsaPkg::opSra;
                end
            end
            default: nextOp = rvIsaPkg::opIllegal;
        endcase
    end

    ////////////////////////////////////////////////////////////
    // stage register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            validQ <= 1'b0;
        end else if (rdy) begin
            validQ <= issueEn; // an issue while rdy is low is dropped
        end
    end

    always_ff @(posedge clk) begin
        if (rdy && issueEn) begin
            decOp  <= nextOp;
            decImm <= nextImm;
            decPc  <= issuePc;
            decTag <= issueTag;
            decRs1 <= rs1Data;
            decRs2 <= rs2Data;
        end
    end

    // a redirect squashes the instruction sitting here before it moves on
    assign decValid = validQ & ~flush;

endmodule

`default_nettype wire

//--- rtl/execUnit.sv
`timescale 1ns/10ps
`default_nettype none

module execUnit (
    input  wire                 clk,
    input  wire                 rst,
    input  wire                 rdy,
    input  wire                 flush,
    input  wire                 decValid,
    input  wire rvIsaPkg::opT   decOp,
    input  wire pipePkg::dataT  decImm,
    input  wire pipePkg::addrT  decPc,
    input  wire pipePkg::tagT   decTag,
    input  wire pipePkg::dataT  decRs1,
    input  wire pipePkg::dataT  decRs2,
    output logic                exValid,
    output rvIsaPkg::opT        exOp,
    output pipePkg::dataT       exData,
    output logic                exTaken,
    output pipePkg::addrT       exTarget,
    output pipePkg::tagT        exTag,
    output pipePkg::addrT       exPc
);

    pipePkg::dataT opB;
    logic [4:0]    shamt;
    logic          eq;
    logic          ltS;
    logic          ltU;
    pipePkg::addrT pcRel;
    pipePkg::addrT jalrSum;
    pipePkg::dataT result;
    logic          taken;
    pipePkg::addrT target;
    logic          validQ;

    // second ALU operand is the immediate for the OP-IMM group
    assign opB = (decOp inside {rvIsaPkg::opAddi, rvIsaPkg::opSlti, rvIsaPkg::opSltiu,
                                rvIsaPkg::opXori, rvIsaPkg::opOri, rvIsaPkg::opAndi,
                                rvIsaPkg::opSlli, rvIsaPkg::opSrli, rvIsaPkg::opSrai})
                 ? decImm : decRs2;
    assign shamt = opB[4:0];

    // branch compares always use rs2
    assign eq  = (decRs1 == decRs2);
    assign ltS = ($signed(decRs1) < $signed(decRs2));
    assign ltU = (decRs1 < decRs2);

    assign pcRel   = decPc + decImm;
    assign jalrSum = decRs1 + decImm;

    ////////////////////////////////////////////////////////////
    // result and control transfer
    ////////////////////////////////////////////////////////////

    always_comb begin
        result = '0;
        taken  = 1'b0;
        target = pcRel;
        case (decOp)
            rvIsaPkg::opLui:   result = decImm;
            rvIsaPkg::opAuipc: result = pcRel;
            rvIsaPkg::opJal: begin
                result = decPc + 32'd4;
                taken  = 1'b1;
            end
            rvIsaPkg::opJalr: begin
                result = decPc + 32'd4;
                taken  = 1'b1;
                target = {jalrSum[31:1], 1'b0};
            end
            rvIsaPkg::opBeq:  taken = eq;
            rvIsaPkg::opBne:  taken = ~eq;
            rvIsaPkg::opBlt:  taken = ltS;
            rvIsaPkg::opBge:  taken = ~ltS;
            rvIsaPkg::opBltu: taken = ltU;
            rvIsaPkg::opBgeu: taken = ~ltU;
            rvIsaPkg::opAddi, rvIsaPkg::opAdd: result = decRs1 + opB;
            rvIsaPkg::opSub:                   result = decRs1 - opB;
            rvIsaPkg::opSlti, rvIsaPkg::opSlt:
                result = pipePkg::dataT'($signed(decRs1) < $signed(opB));
            rvIsaPkg::opSltiu, rvIsaPkg::opSltu:
                result = pipePkg::dataT'(decRs1 < opB);
            rvIsaPkg::opXori, rvIsaPkg::opXor: result = decRs1 ^ opB;
            rvIsaPkg::opOri, rvIsaPkg::opOr:   result = decRs1 | opB;
            rvIsaPkg::opAndi, rvIsaPkg::opAnd: result = decRs1 & opB;
            rvIsaPkg::opSlli, rvIsaPkg::opSll: result = decRs1 << shamt;
            rvIsaPkg::opSrli, rvIsaPkg::opSrl: result = decRs1 >> shamt;
            rvIsaPkg::opSrai, rvIsaPkg::opSra:
                result = pipePkg::dataT'($signed(decRs1) >>> shamt);
            default: result = '0; // illegal goes out as an exception instead
        endcase
    end

    ////////////////////////////////////////////////////////////
    // stage register
    ////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            validQ <= 1'b0;
        end else if (rdy) begin
            validQ <= decValid;
        end
    end

    always_ff @(posedge clk) begin
        if (rdy && decValid) begin
            exOp     <= decOp;
            exData   <= result;
            exTaken  <= taken;
            exTarget <= target;
            exTag    <= decTag;
            exPc     <= decPc;
        end
    end

    assign exValid = validQ & ~flush; // the older squashed slot

endmodule

`default_nettype wire

//--- rtl/resultBroadcast.sv
`timescale 1ns/10ps
`default_nettype none

module resultBroadcast (
    input  wire                 clk,
    input  wire                 rst,
    input  wire                 rdy,
    input  wire                 exValid,
    input  wire rvIsaPkg::opT   exOp,
    input  wire pipePkg::dataT  exData,
    input  wire                 exTaken,
    input  wire pipePkg::addrT  exTarget,
    input  wire pipePkg::tagT   exTag,
    input  wire pipePkg::addrT  exPc,
    output logic                cdbEn,
    output pipePkg::tagT        cdbTag,
    output pipePkg::dataT       cdbData,
    output logic                redirectEn,
    output pipePkg::addrT       redirectPc,
    output logic                excEn,
    output pipePkg::addrT       excPc,
    output logic                flush
);

    logic isBranch;
    logic isIllegal;

    // branches have no destination register
    assign isBranch = exOp inside {rvIsaPkg::opBeq, rvIsaPkg::opBne, rvIsaPkg::opBlt,
                                   rvIsaPkg::opBge, rvIsaPkg::opBltu, rvIsaPkg::opBgeu};
    assign isIllegal = (exOp == rvIsaPkg::opIllegal);

    always_ff @(posedge clk) begin
        if (rst) begin
            cdbEn      <= 1'b0;
            redirectEn <= 1'b0;
            excEn      <= 1'b0;
        end else if (rdy) begin
            cdbEn      <= exValid & ~isIllegal & ~isBranch;
            redirectEn <= exValid & exTaken;
            excEn      <= exValid & isIllegal;
        end
    end

    always_ff @(posedge clk) begin
        if (rdy && exValid) begin
            cdbTag     <= exTag;
            cdbData    <= exData;
            redirectPc <= exTarget;
            excPc      <= exPc;
        end
    end

    // only acts on an edge that actually advances the pipe
    assign flush = redirectEn & rdy;

endmodule

`default_nettype wire

//--- rtl/aluStation.sv
`timescale 1ns/10ps
`default_nettype none

module aluStation (
    input  wire                 clk,
    input  wire                 rst,
    input  wire                 rdy,
    input  wire                 issueEn,
    input  wire pipePkg::addrT  issuePc,
    input  wire pipePkg::dataT  issueInstr,
    input  wire pipePkg::tagT   issueTag,
    input  wire pipePkg::dataT  rs1Data,
    input  wire pipePkg::dataT  rs2Data,
    output logic                cdbEn,
    output pipePkg::tagT        cdbTag,
    output pipePkg::dataT       cdbData,
    output logic                redirectEn,
    output pipePkg::addrT       redirectPc,
    output logic                excEn,
    output pipePkg::addrT       excPc
);

    ////////////////////////////////////////////////////////////
    // decode to execute
    ////////////////////////////////////////////////////////////

    logic          decValid;
    rvIsaPkg::opT  decOp;
    pipePkg::dataT decImm;
    pipePkg::addrT decPc;
    pipePkg::tagT  decTag;
    pipePkg::dataT decRs1;
    pipePkg::dataT decRs2;

    // execute to result
    logic          exValid;
    rvIsaPkg::opT  exOp;
    pipePkg::dataT exData;
    logic          exTaken;
    pipePkg::addrT exTarget;
    pipePkg::tagT  exTag;
    pipePkg::addrT exPc;

    logic flush; // back from the result stage

    instrDecode i_instrDecode (
        .clk(clk), .rst(rst), .rdy(rdy), .flush(flush),
        .issueEn(issueEn), .issuePc(issuePc), .issueInstr(issueInstr),
        .issueTag(issueTag), .rs1Data(rs1Data), .rs2Data(rs2Data),
        .decValid(decValid), .decOp(decOp), .decImm(decImm), .decPc(decPc),
        .decTag(decTag), .decRs1(decRs1), .decRs2(decRs2)
    );

    execUnit i_execUnit (
        .clk(clk), .rst(rst), .rdy(rdy), .flush(flush),
        .decValid(decValid), .decOp(decOp), .decImm(decImm), .decPc(decPc),
        .decTag(decTag), .decRs1(decRs1), .decRs2(decRs2),
        .exValid(exValid), .exOp(exOp), .exData(exData), .exTaken(exTaken),
        .exTarget(exTarget), .exTag(exTag), .exPc(exPc)
    );

    resultBroadcast i_resultBroadcast (
        .clk(clk), .rst(rst), .rdy(rdy),
        .exValid(exValid), .exOp(exOp), .exData(exData), .exTaken(exTaken),
        .exTarget(exTarget), .exTag(exTag), .exPc(exPc),
        .cdbEn(cdbEn), .cdbTag(cdbTag), .cdbData(cdbData),
        .redirectEn(redirectEn), .redirectPc(redirectPc),
        .excEn(excEn), .excPc(excPc), .flush(flush)
    );

endmodule

`default_nettype wire

//--- dv/aluStationSva.sv
`timescale 1ns/10ps

`include "aluStation_macros.svh"

`default_nettype none

module aluStationSva (
    input wire                clk,
    input wire                rst,
    input wire                rdy,
    input wire                cdbEn,
    input wire pipePkg::tagT  cdbTag,
    input wire pipePkg::dataT cdbData,
    input wire                redirectEn,
    input wire pipePkg::addrT redirectPc,
    input wire                excEn,
    input wire pipePkg::addrT excPc
);

    logic [1:0] squashLeft; // rdy-high edges still covered by the last redirect

    always_ff @(posedge clk) begin
        if (rst) begin
            squashLeft <= '0;
        end else if (rdy) begin
            if (redirectEn) squashLeft <= 2'(`SQUASH_DEPTH);
            else if (squashLeft != 0) squashLeft <= squashLeft - 2'd1;
        end
    end

    ////////////////////////////////////////////////////////////
    // output protocol
    ////////////////////////////////////////////////////////////

    resetClears: assert property (@(posedge clk) rst |=> !cdbEn && !redirectEn && !excEn)
        else $error("outputs not cleared after reset");

    redirectNotExc: assert property (@(posedge clk) disable iff (rst) !(redirectEn && excEn))
        else $error("redirect and exception raised together");

    // the two killed slots must leave the output quiet
    squashQuiet: assert property (@(posedge clk) disable iff (rst)
        squashLeft != 0 |-> !cdbEn && !redirectEn && !excEn)
        else $error("output seen from a squashed slot");

    stallHoldsEnables: assert property (@(posedge clk) disable iff (rst)
        !rdy |=> $stable({cdbEn, redirectEn, excEn}))
        else $error("strobes changed during a stall");

    stallHoldsData: assert property (@(posedge clk) disable iff (rst)
        (!rdy && cdbEn) |=> $stable({cdbTag, cdbData}))
        else $error("broadcast changed during a stall");

    stallHoldsTargets: assert property (@(posedge clk) disable iff (rst)
        (!rdy && (redirectEn || excEn)) |=> $stable({redirectPc, excPc}))
        else $error("redirect or exception PC changed during a stall");

endmodule

`default_nettype wire

//--- dv/aluStationTb.sv
`timescale 1ns/10ps

`include "aluStation_macros.svh"

`default_nettype none

module aluStationTb;

    typedef struct {
        string         name;
        logic          cdb;
        pipePkg::tagT  tag;
        pipePkg::dataT data;
        logic          redir;
        pipePkg::addrT rpc;
        logic          exc;
        int            due;
    } expT;

    logic clk = 1'b0;
    logic rst, rdy, issueEn;
    pipePkg::addrT issuePc;
    pipePkg::dataT issueInstr, rs1Data, rs2Data;
    pipePkg::tagT  issueTag;
    wire cdbEn, redirectEn, excEn;
    pipePkg::tagT  cdbTag;
    pipePkg::dataT cdbData;
    pipePkg::addrT redirectPc, excPc;

    logic [31:0] lfsr;
    expT         expQ[$];
    int          squashLeft;
    int          edges;
    logic        stepped;

    always #4 clk = ~clk;

    aluStation i_aluStation (.*);

    bind aluStation aluStationSva i_aluStationSva (
        .clk(clk), .rst(rst), .rdy(rdy), .cdbEn(cdbEn), .cdbTag(cdbTag),
        .cdbData(cdbData), .redirectEn(redirectEn), .redirectPc(redirectPc),
        .excEn(excEn), .excPc(excPc)
    );

    // x^32 + x^22 + x^2 + x + 1, one step per bit taken
    function automatic logic [31:0] rnd(input int bits);
        logic [31:0] r;
        r = '0;
        for (int i = 0; i < bits; i++) begin
            lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
            r = {r[30:0], lfsr[0]};
        end
        return r;
    endfunction

    function automatic logic [31:0] aluResult(input logic [2:0] f3, input logic alt,
                                               input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return {31'b0, $signed(a) < $signed(b)};
            3'd3: return {31'b0, a < b};
            3'd4: return a ^ b;
            3'd5: return alt ? 32'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic branchTaken(input logic [2:0] f3, input logic [31:0] a,
                                         input logic [31:0] b);
        case (f3)
            3'd0: return a == b;
            3'd1: return a != b;
            3'd4: return $signed(a) < $signed(b);
            3'd5: return $signed(a) >= $signed(b);
            3'd6: return a < b;
            default: return a >= b;
        endcase
    endfunction

    task automatic failRun();
        $display("TEST FAILED");
        $fatal(1, "stopping at first error");
    endtask

    task automatic checkValue(string name, string field, logic [31:0] expVal,
                              logic [31:0] actVal);
        assert (expVal === actVal) else begin
            $display("error %s %s: expected %h actual %h", name, field, expVal, actVal);
            failRun();
        end
    endtask

    ////////////////////////////////////////////////////////////
    // scoreboard, sampled mid-cycle after a rdy-high edge
    ////////////////////////////////////////////////////////////

    always @(posedge clk) begin
        stepped = rdy && !rst;
        if (stepped) edges++; // counts the edges that move the pipe
    end

    always @(negedge clk) begin
        expT e;
        if (stepped && (cdbEn || redirectEn || excEn)) begin
            if (expQ.size() == 0) begin
                $display("an output appeared while no result was expected");
                failRun();
            end else begin
                e = expQ.pop_front();
                checkValue(e.name, "outputEdge", 32'(e.due), 32'(edges));
                checkValue(e.name, "cdbEn", 32'(e.cdb), 32'(cdbEn));
                checkValue(e.name, "redirectEn", 32'(e.redir), 32'(redirectEn));
                checkValue(e.name, "excEn", 32'(e.exc), 32'(excEn));
                if (e.cdb) checkValue(e.name, "cdbTag", 32'(e.tag), 32'(cdbTag));
                if (e.cdb) checkValue(e.name, "cdbData", e.data, cdbData);
                if (e.redir) checkValue(e.name, "redirectPc", e.rpc, redirectPc);
                if (e.exc) checkValue(e.name, "excPc", e.rpc, excPc);
            end
        end
    end

    // builds one random instruction, predicts it and holds it until accepted
    task automatic issueRandom();
        logic [3:0]  kind;
        logic [2:0]  f3;
        logic        alt;
        logic        acc;
        logic [4:0]  rd;
        logic [31:0] instr, pc, a, b, imm, r;
        expT         e;
        int          waits;
        kind = 4'(rnd(4));
        f3 = 3'(rnd(3));
        alt = 1'(rnd(1));
        rd = 5'(rnd(5));
        pc = rnd(30) << 2;
        a = rnd(32);
        b = rnd(32);
        r = rnd(20);
        imm = {{20{r[11]}}, r[11:0]};
        e.tag = pipePkg::tagT'(rnd(4));
        e.cdb = 1'b0;
        e.redir = 1'b0;
        e.exc = 1'b0;
        e.data = '0;
        e.rpc = '0;
        if (kind < 4'd5) begin
            if (f3 != 3'd0 && f3 != 3'd5) alt = 1'b0;
            instr = {alt ? rvIsaPkg::f7Alt : rvIsaPkg::f7Base, 5'd2, 5'd1, f3, rd,
                     rvIsaPkg::opcodeOp};
            e.name = "regAlu";
            e.cdb = 1'b1;
            e.data = aluResult(f3, alt, a, b);
        end else if (kind < 4'd9) begin
            if (f3 == 3'd1) imm = {27'b0, imm[4:0]};
            if (f3 == 3'd5) imm = {20'b0, alt ? rvIsaPkg::f7Alt : rvIsaPkg::f7Base, imm[4:0]};
            else alt = 1'b0;
            instr = {imm[11:0], 5'd1, f3, rd, rvIsaPkg::opcodeOpImm};
            e.name = "immAlu";
            e.cdb = 1'b1;
            e.data = aluResult(f3, alt, a, imm);
        end else if (kind < 4'd11) begin
            imm = {r[19:0], 12'b0};
            instr = {r[19:0], rd, kind == 4'd9 ? rvIsaPkg::opcodeLui : rvIsaPkg::opcodeAuipc};
            e.name = "upperImm";
            e.cdb = 1'b1;
            e.data = kind == 4'd9 ? imm : pc + imm;
        end else if (kind < 4'd13) begin
            if (f3 == 3'd2 || f3 == 3'd3) f3 = f3 + 3'd4;
            if (r[19:18] == 2'b0) b = a; // equal operands now and then
            imm = {{19{r[11]}}, r[11:0], 1'b0};
            instr = {imm[12], imm[10:5], 5'd2, 5'd1, f3, imm[4:1], imm[11],
                     rvIsaPkg::opcodeBranch};
            e.name = "branch";
            e.redir = branchTaken(f3, a, b);
            e.rpc = pc + imm;
        end else if (kind == 4'd13) begin
            imm = {{11{r[19]}}, r[19:0], 1'b0};
            instr = {imm[20], imm[10:1], imm[11], imm[19:12], rd, rvIsaPkg::opcodeJal};
            e.name = "jal";
            e.cdb = 1'b1;
            e.data = pc + 4;
            e.redir = 1'b1;
            e.rpc = pc + imm;
        end else if (kind == 4'd14) begin
            instr = {imm[11:0], 5'd1, rvIsaPkg::f3Jalr, rd, rvIsaPkg::opcodeJalr};
            e.name = "jalr";
            e.cdb = 1'b1;
            e.data = pc + 4;
            e.redir = 1'b1;
            e.rpc = (a + imm) & ~32'd1;
        end else begin
            instr = {25'(rnd(25)), 7'b0000011}; // loads are outside the slice
            e.name = "illegal";
            e.exc = 1'b1;
            e.rpc = pc;
        end
        {issueEn, issuePc, issueInstr, issueTag, rs1Data, rs2Data} =
            {1'b1, pc, instr, e.tag, a, b};
        waits = 0;
        acc = 1'b0;
        while (!acc) begin
            @(posedge clk);
            acc = rdy;
            #1;
            rdy = (rnd(3) != 0); // short random stalls
            waits++;
            if (waits > 100) begin
                $display("timeout: issue was never accepted");
                failRun();
            end
        end
        issueEn = 1'b0;
        e.due = edges + 2; // decode took it on the edge just counted
        if (squashLeft > 0) begin
            squashLeft--;
        end else begin
            if (e.cdb || e.redir || e.exc) expQ.push_back(e);
            if (e.redir) squashLeft = `SQUASH_DEPTH;
        end
    endtask

    initial begin
        int waits;
        lfsr = 32'h3d72;
        {rst, rdy, issueEn, issuePc, issueInstr, issueTag, rs1Data, rs2Data} = {2'b11, 1'b0, 132'b0};
        squashLeft = 0;
        edges = 0;
        repeat (4) @(posedge clk);
        #1 rst = 1'b0;
        for (int n = 0; n < 600; n++) issueRandom();
        rdy = 1'b1;
        waits = 0;
        while (expQ.size() != 0 && waits < 100) begin
            @(negedge clk);
            waits++;
        end
        @(negedge clk);
        if (expQ.size() == 0) begin
            $display("TEST OK");
            $finish;
        end else begin
            $display("timeout: %0d results never appeared", expQ.size());
            $display("TEST FAILED");
            $fatal(1, "run ended with errors");
        end
    end

endmodule

`default_nettype wire

//--- files.f
+incdir+rtl
rtl/rvIsaPkg.sv
rtl/pipePkg.sv
rtl/instrDecode.sv
rtl/execUnit.sv
rtl/resultBroadcast.sv
rtl/aluStation.sv
dv/aluStationSva.sv
dv/aluStationTb.sv

//--- run.sh
#!/bin/sh
# Build and run the aluStation testbench with Verilator.
cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --assert -f files.f --top-module aluStationTb \
        -Mdir obj_dir -o aluStationSim; then
    echo "build failed"
    exit 1
fi

./obj_dir/aluStationSim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
fi

if grep -q "^TEST OK$" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1
